// File: verilog/ex_pkg.sv
package ex_pkg;

    // --------------------
    // widths
    // --------------------
    localparam int XLEN   = 32;
    localparam int REG_AW = 5;

    // funct3 comparator codes
    localparam logic [2:0] CMP_EQ  = 3'b000;
    localparam logic [2:0] CMP_NE  = 3'b001;
    localparam logic [2:0] CMP_LT  = 3'b100;
    localparam logic [2:0] CMP_GE  = 3'b101;
    localparam logic [2:0] CMP_LTU = 3'b110;
    localparam logic [2:0] CMP_GEU = 3'b111;

    // --------------------
    // enumerations
    // --------------------
    typedef enum logic [3:0] {
        ALU_ADD  = 4'd0,
        ALU_SUB  = 4'd1,
        ALU_AND  = 4'd2,
        ALU_OR   = 4'd3,
        ALU_XOR  = 4'd4,
        ALU_SLL  = 4'd5,
        ALU_SRL  = 4'd6,
        ALU_SRA  = 4'd7,
        ALU_SLT  = 4'd8,
        ALU_SLTU = 4'd9
    } alu_op_t;

    // destination of the result
    typedef enum logic [1:0] {
        ZONE_NONE    = 2'd0,
        ZONE_REGFILE = 2'd1,
        ZONE_LOADQ   = 2'd2,
        ZONE_STOREQ  = 2'd3
    } zone_t;

    typedef enum logic {
        SOF_RUN  = 1'b0,
        SOF_JUMP = 1'b1
    } sof_t;

    // --------------------
    // structs
    // --------------------
    typedef struct packed {
        logic                valid;
        sof_t                sof;
        logic [1:0]          ins_size;
        logic                jump;
        logic                cond;
        zone_t               zone;
        logic                link;
        logic [XLEN-1:0]     pc;
        alu_op_t             alu_op;
        logic [XLEN-1:0]     operand_left;
        logic [XLEN-1:0]     operand_right;
        logic [XLEN-1:0]     cmp_left;
        logic [XLEN-1:0]     cmp_right;
        logic [XLEN-1:0]     regs2_data;
        logic [REG_AW-1:0]   regd_addr;
        logic [2:0]          funct3;
    } dec_ins_t;

    // registered instruction, zone already decoded
    typedef struct packed {
        logic                valid;
        logic                run;
        logic                jump;
        logic                cond;
        logic                lq_wr;
        logic                sq_wr;
        logic                regd_wr;
        logic                link;
        logic [XLEN-1:0]     pc_inc;
        logic [XLEN-1:0]     regs2_data;
        logic [REG_AW-1:0]   regd_addr;
        logic [2:0]          funct3;
    } held_ins_t;

    typedef struct packed {
        logic [XLEN-1:0] data;
        logic            cmp;
    } alu_res_t;

    typedef struct packed {
        logic              wr;
        logic              cncl_load;
        logic [REG_AW-1:0] addr;
        logic [XLEN-1:0]   data;
    } wb_t;

    typedef struct packed {
        logic              lq_wr;
        logic              sq_wr;
        logic [2:0]        funct3;
        logic [REG_AW-1:0] regd_addr;
        logic [XLEN-1:0]   regs2_data;
        logic [XLEN-1:0]   addr;
    } lsq_req_t;

endpackage

// File: verilog/ex_issue_reg.sv
`timescale 1ns/1ns

module ex_issue_reg (
    input  logic             clk_i,
    input  logic             reset_i,
    input  logic             stage_en_i,
    input  logic             jump_i,
    input  ex_pkg::dec_ins_t dec_i,
    output ex_pkg::held_ins_t held_o
);
    import ex_pkg::*;

    // control state
    logic                valid_q;
    sof_t                stream_q;
    // payload
    logic                jump_q;
    logic                cond_q;
    logic                lq_wr_q;
    logic                sq_wr_q;
    logic                regd_wr_q;
    logic                link_q;
    logic [XLEN-1:0]     pc_inc_q;
    logic [XLEN-1:0]     regs2_data_q;
    logic [REG_AW-1:0]   regd_addr_q;
    logic [2:0]          funct3_q;

    // --------------------
    // stream restart
    // --------------------
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            valid_q  <= 1'b0;
            stream_q <= SOF_RUN;
        end else if (stage_en_i) begin
            valid_q <= dec_i.valid;
            // a redirect wins over a restart sampled at the same edge
            if (jump_i) begin
                stream_q <= SOF_JUMP;
            end else if (dec_i.valid && dec_i.sof == SOF_JUMP) begin
                stream_q <= SOF_RUN;
            end
        end
    end

    // --------------------
    // delay register
    // --------------------
    always_ff @(posedge clk_i) begin
        if (stage_en_i) begin
            jump_q       <= dec_i.jump;
            cond_q       <= dec_i.cond;
            link_q       <= dec_i.link;
            // zone to one-hot strobes
            lq_wr_q      <= (dec_i.zone == ZONE_LOADQ);
            sq_wr_q      <= (dec_i.zone == ZONE_STOREQ);
            regd_wr_q    <= (dec_i.zone == ZONE_REGFILE);
            // ins_size counts halfwords
            pc_inc_q     <= dec_i.pc + {{(XLEN-3){1'b0}}, dec_i.ins_size, 1'b0};
            regs2_data_q <= dec_i.regs2_data;
            regd_addr_q  <= dec_i.regd_addr;
            funct3_q     <= dec_i.funct3;
        end
    end

    always_comb begin
        held_o.valid      = valid_q;
        held_o.run        = (stream_q == SOF_RUN);
        held_o.jump       = jump_q;
        held_o.cond       = cond_q;
        held_o.lq_wr      = lq_wr_q;
        held_o.sq_wr      = sq_wr_q;
        held_o.regd_wr    = regd_wr_q;
        held_o.link       = link_q;
        held_o.pc_inc     = pc_inc_q;
        held_o.regs2_data = regs2_data_q;
        held_o.regd_addr  = regd_addr_q;
        held_o.funct3     = funct3_q;
    end

    a_zone_onehot: assert property (@(posedge clk_i) disable iff (reset_i)
        valid_q |-> $onehot0({lq_wr_q, sq_wr_q, regd_wr_q}));

endmodule

// File: verilog/ex_alu.sv
`timescale 1ns/1ns

module ex_alu (
    input  logic                    clk_i,
    input  logic                    stage_en_i,
    input  ex_pkg::alu_op_t         op_i,
    input  logic [ex_pkg::XLEN-1:0] left_i,
    input  logic [ex_pkg::XLEN-1:0] right_i,
    input  logic [ex_pkg::XLEN-1:0] cmp_left_i,
    input  logic [ex_pkg::XLEN-1:0] cmp_right_i,
    input  logic [2:0]              cmp_op_i,
    output ex_pkg::alu_res_t        res_o
);
    import ex_pkg::*;

    logic [XLEN-1:0] alu_data;
    logic            cmp_out;
    logic [4:0]      shamt;
    logic            lt_s;
    logic            lt_u;

    assign shamt = right_i[4:0];

    // --------------------
    // alu
    // --------------------
    always_comb begin
        case (op_i)
            ALU_ADD:  alu_data = left_i + right_i;
            ALU_SUB:  alu_data = left_i - right_i;
            ALU_AND:  alu_data = left_i & right_i;
            ALU_OR:   alu_data = left_i | right_i;
            ALU_XOR:  alu_data = left_i ^ right_i;
            ALU_SLL:  alu_data = left_i << shamt;
            ALU_SRL:  alu_data = left_i >> shamt;
            ALU_SRA:  alu_data = $signed(left_i) >>> shamt;
            ALU_SLT: begin
                alu_data = {{(XLEN-1){1'b0}}, $signed(left_i) < $signed(right_i)};
            end
            ALU_SLTU: begin
                alu_data = {{(XLEN-1){1'b0}}, left_i < right_i};
            end
            default:  alu_data = '0;
        endcase
    end

    // --------------------
    // branch comparator
    // --------------------
    assign lt_s = $signed(cmp_left_i) < $signed(cmp_right_i);
    assign lt_u = cmp_left_i < cmp_right_i;

    always_comb begin
        case (cmp_op_i)
            CMP_EQ:  cmp_out = (cmp_left_i == cmp_right_i);
            CMP_NE:  cmp_out = (cmp_left_i != cmp_right_i);
            CMP_LT:  cmp_out = lt_s;
            CMP_GE:  cmp_out = ~lt_s;
            CMP_LTU: cmp_out = lt_u;
            CMP_GEU: cmp_out = ~lt_u;
            // codes 010 and 011 never compare true
            default: cmp_out = 1'b0;
        endcase
    end

    // lines up with the held instruction
    always_ff @(posedge clk_i) begin
        if (stage_en_i) begin
            res_o.data <= alu_data;
            res_o.cmp  <= cmp_out;
        end
    end

endmodule

// File: verilog/ex_commit.sv
`timescale 1ns/1ns

module ex_commit (
    input  ex_pkg::held_ins_t       held_i,
    input  ex_pkg::alu_res_t        alu_i,
    input  logic                    lsq_full_i,
    output logic                    stage_en_o,
    output logic                    jump_o,
    output ex_pkg::wb_t             wb_o,
    output ex_pkg::lsq_req_t        lsq_o,
    output logic [ex_pkg::XLEN-1:0] jump_addr_o
);
    import ex_pkg::*;

    logic commit;
    logic mem_op;
    logic stall;

    // --------------------
    // commit decision
    // --------------------
    // unconditional, or the compare holds
    assign commit = held_i.valid & held_i.run & (alu_i.cmp | ~held_i.cond);

    assign mem_op = held_i.lq_wr | held_i.sq_wr;

    // --------------------
    // stall
    // --------------------
    // only a committing load or store can wait on the queue
    assign stall      = commit & mem_op & lsq_full_i;
    assign stage_en_o = ~stall;

    // --------------------
    // redirect
    // --------------------
    assign jump_o      = stage_en_o & commit & held_i.jump;
    assign jump_addr_o = {alu_i.data[XLEN-1:1], 1'b0};

    // --------------------
    // writeback
    // --------------------
    always_comb begin
        wb_o.wr        = stage_en_o & commit & held_i.regd_wr;
        // decoder releases the scoreboard entry of a dropped load
        wb_o.cncl_load = stage_en_o & ~commit & held_i.valid & held_i.lq_wr;
        wb_o.addr      = held_i.regd_addr;
        if (held_i.link) begin
            wb_o.data = held_i.pc_inc;
        end else begin
            wb_o.data = alu_i.data;
        end
    end

    // --------------------
    // load/store queue
    // --------------------
    always_comb begin
        lsq_o.lq_wr      = stage_en_o & commit & held_i.lq_wr;
        lsq_o.sq_wr      = stage_en_o & commit & held_i.sq_wr;
        lsq_o.funct3     = held_i.funct3;
        lsq_o.regd_addr  = held_i.regd_addr;
        lsq_o.regs2_data = held_i.regs2_data;
        lsq_o.addr       = alu_i.data;
    end

    // strobe exclusivity
    always_comb begin
        a_lsq_excl: assert final (!(lsq_o.lq_wr && lsq_o.sq_wr))
            else $error("load and store issued together");
        a_no_jump_stall: assert final (!(jump_o && !stage_en_o))
            else $error("redirect during stall");
    end

endmodule

// File: verilog/ex_stage.sv
`timescale 1ns/1ns

module ex_stage (
    input  logic                    clk_i,
    input  logic                    reset_i,
    input  ex_pkg::dec_ins_t        dec_ins_i,
    input  logic                    lsq_full_i,
    output logic                    ids_stall_o,
    output ex_pkg::wb_t             wb_o,
    output ex_pkg::lsq_req_t        lsq_o,
    output logic                    pfu_jump_o,
    output logic [ex_pkg::XLEN-1:0] pfu_jump_addr_o
);
    import ex_pkg::*;

    held_ins_t held;
    alu_res_t  alu_res;
    logic      stage_en;

    assign ids_stall_o = ~stage_en;

    // --------------------
    // input side
    // --------------------
    ex_issue_reg i_issue_reg (
        .clk_i      (clk_i),
        .reset_i    (reset_i),
        .stage_en_i (stage_en),
        .jump_i     (pfu_jump_o),
        .dec_i      (dec_ins_i),
        .held_o     (held)
    );

    ex_alu i_alu (
        .clk_i       (clk_i),
        .stage_en_i  (stage_en),
        .op_i        (dec_ins_i.alu_op),
        .left_i      (dec_ins_i.operand_left),
        .right_i     (dec_ins_i.operand_right),
        .cmp_left_i  (dec_ins_i.cmp_left),
        .cmp_right_i (dec_ins_i.cmp_right),
        .cmp_op_i    (dec_ins_i.funct3),
        .res_o       (alu_res)
    );

    // --------------------
    // output side
    // --------------------
    ex_commit i_commit (
        .held_i      (held),
        .alu_i       (alu_res),
        .lsq_full_i  (lsq_full_i),
        .stage_en_o  (stage_en),
        .jump_o      (pfu_jump_o),
        .wb_o        (wb_o),
        .lsq_o       (lsq_o),
        .jump_addr_o (pfu_jump_addr_o)
    );

endmodule

// File: bench/tb_ex_stage.sv
`timescale 1ns/1ns

module tb_ex_stage;
    import ex_pkg::*;

    localparam int NUM_INS    = 600;
    localparam int DRAIN      = 4;
    // a store holds the queue full for at most 4 cycles
    localparam int MAX_CYCLES = NUM_INS * 5;

    logic            clk_i;
    logic            reset_i;
    dec_ins_t        dec_ins_i;
    logic            lsq_full_i;
    logic            ids_stall_o;
    wb_t             wb_o;
    lsq_req_t        lsq_o;
    logic            pfu_jump_o;
    logic [XLEN-1:0] pfu_jump_addr_o;

    logic [31:0] seed;
    int          cycles;
    logic        taken;
    // model of the held instruction and stream state
    dec_ins_t    m_ins;
    logic        m_valid;
    logic        m_run;

    ex_stage i_dut (
        .clk_i           (clk_i),
        .reset_i         (reset_i),
        .dec_ins_i       (dec_ins_i),
        .lsq_full_i      (lsq_full_i),
        .ids_stall_o     (ids_stall_o),
        .wb_o            (wb_o),
        .lsq_o           (lsq_o),
        .pfu_jump_o      (pfu_jump_o),
        .pfu_jump_addr_o (pfu_jump_addr_o)
    );

    always #4 clk_i = ~clk_i;

    function automatic logic [31:0] next_rand();
        logic [31:0] x;
        x    = seed;
        x    = x ^ (x << 13);
        x    = x ^ (x >> 17);
        x    = x ^ (x << 5);
        seed = x;
        return x;
    endfunction

    // --------------------
    // reference
    // --------------------
    function automatic alu_res_t exec_ref(input dec_ins_t d);
        alu_res_t    r;
        logic [31:0] a;
        logic [31:0] b;
        logic [4:0]  sh;
        logic        slt;
        logic        clt;
        a   = d.operand_left;
        b   = d.operand_right;
        sh  = b[4:0];
        // signed order by flipping the sign bits
        slt = (a ^ 32'h8000_0000) < (b ^ 32'h8000_0000);
        clt = (d.cmp_left ^ 32'h8000_0000) < (d.cmp_right ^ 32'h8000_0000);
        case (d.alu_op)
            ALU_ADD:  r.data = a + b;
            ALU_SUB:  r.data = a - b;
            ALU_AND:  r.data = a & b;
            ALU_OR:   r.data = a | b;
            ALU_XOR:  r.data = a ^ b;
            ALU_SLL:  r.data = a << sh;
            ALU_SRL:  r.data = a >> sh;
            ALU_SRA: begin
                r.data = a >> sh;
                if (a[31]) begin
                    r.data = r.data | ~(32'hffff_ffff >> sh);
                end
            end
            ALU_SLT:  r.data = {31'd0, slt};
            ALU_SLTU: r.data = {31'd0, a < b};
            default:  r.data = 32'd0;
        endcase
        case (d.funct3)
            CMP_EQ:  r.cmp = (d.cmp_left == d.cmp_right);
            CMP_NE:  r.cmp = (d.cmp_left != d.cmp_right);
            CMP_LT:  r.cmp = clt;
            CMP_GE:  r.cmp = !clt;
            CMP_LTU: r.cmp = (d.cmp_left < d.cmp_right);
            CMP_GEU: r.cmp = !(d.cmp_left < d.cmp_right);
            default: r.cmp = 1'b0;
        endcase
        return r;
    endfunction

    task automatic check_val(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
        if (got !== exp) begin
            $display("FAIL %s: got %h, expected %h", name, got, exp);
            $display("Result: FAILED");
            $fatal(1, "value mismatch on %s", name);
        end
    endtask

    // --------------------
    // stimulus
    // --------------------
    task automatic make_ins(input int idx, output dec_ins_t d, output int full_len);
        logic [31:0] r;
        int          kind;
        r        = next_rand();
        d        = '0;
        full_len = 0;
        if (idx < NUM_INS) begin
            d.valid         = (r[2:0] != 3'd0);
            d.sof           = (r[4:3] == 2'd0) ? SOF_JUMP : SOF_RUN;
            d.ins_size      = r[5] ? 2'd2 : 2'd1;
            d.pc            = next_rand() & 32'hffff_fffe;
            d.operand_left  = next_rand();
            d.operand_right = next_rand();
            d.cmp_left      = next_rand();
            d.cmp_right     = r[6] ? d.cmp_left : next_rand();
            d.regs2_data    = next_rand();
            d.regd_addr     = r[12:8];
            d.funct3        = r[15:13];
            d.alu_op        = alu_op_t'(4'(idx % 10));
            // plain ALU work first, then a mix
            kind = (idx < 100) ? 0 : int'(r[18:16]) % 6;
            case (kind)
                2: begin
                    d.jump   = 1'b1;
                    d.cond   = 1'b1;
                    d.alu_op = ALU_ADD;
                end
                3: begin
                    d.zone   = ZONE_LOADQ;
                    d.cond   = r[19];
                    d.alu_op = ALU_ADD;
                end
                4: begin
                    d.zone   = ZONE_STOREQ;
                    d.alu_op = ALU_ADD;
                    full_len = 2 + int'(r[21:20]) % 3;
                end
                5: begin
                    d.zone   = ZONE_REGFILE;
                    d.jump   = 1'b1;
                    d.link   = 1'b1;
                    d.alu_op = ALU_ADD;
                end
                default: d.zone = ZONE_REGFILE;
            endcase
        end
    endtask

    initial begin
        dec_ins_t nxt;
        int       full_cnt;
        int       full_len;
        int       issued;
        logic     advance;
        clk_i      = 1'b0;
        reset_i    = 1'b1;
        dec_ins_i  = '0;
        lsq_full_i = 1'b0;
        seed       = 32'h15ed;
        cycles     = 0;
        full_cnt   = 0;
        issued     = 0;
        advance    = 1'b1;
        repeat (2) @(posedge clk_i);
        #1;
        reset_i = 1'b0;
        while (issued < NUM_INS + DRAIN) begin
            // a stalled stage keeps the old instruction on its inputs
            if (advance) begin
                make_ins(issued, nxt, full_len);
                dec_ins_i = nxt;
                issued    = issued + 1;
                if (full_len != 0) begin
                    full_cnt = full_len;
                end
            end
            if (full_cnt != 0) begin
                lsq_full_i = 1'b1;
                full_cnt   = full_cnt - 1;
            end else begin
                lsq_full_i = 1'b0;
            end
            @(posedge clk_i);
            advance = taken;
            #1;
        end
        repeat (2) @(posedge clk_i);
        $display("Result: PASSED");
        $finish;
    end

    always @(posedge clk_i) begin
        cycles = cycles + 1;
        if (cycles > MAX_CYCLES) begin
            $display("timeout: no end of test after %0d cycles", cycles);
            $display("Result: FAILED");
            $fatal(1, "timeout");
        end
    end

    // --------------------
    // comparing process
    // --------------------
    // inputs and outputs are settled at mid-cycle
    always @(negedge clk_i) begin
        alu_res_t    res;
        logic        commit;
        logic        is_ld;
        logic        is_st;
        logic        stall;
        logic        en;
        logic        exp_jump;
        logic [31:0] exp_data;
        if (reset_i) begin
            m_valid = 1'b0;
            m_run   = 1'b1;
            m_ins   = '0;
            taken   = 1'b0;
        end else begin
            res    = exec_ref(m_ins);
            commit = m_valid && m_run && (res.cmp || !m_ins.cond);
            is_ld  = (m_ins.zone == ZONE_LOADQ);
            is_st  = (m_ins.zone == ZONE_STOREQ);
            stall  = commit && (is_ld || is_st) && lsq_full_i;
            en     = !stall;
            exp_jump = en && commit && m_ins.jump;
            check_val("ids_stall_o", 32'(ids_stall_o), 32'(stall));
            check_val("wb_o.wr", 32'(wb_o.wr),
                      32'(en && commit && m_ins.zone == ZONE_REGFILE));
            check_val("wb_o.cncl_load", 32'(wb_o.cncl_load),
                      32'(en && !commit && m_valid && is_ld));
            check_val("lsq_o.lq_wr", 32'(lsq_o.lq_wr), 32'(en && commit && is_ld));
            check_val("lsq_o.sq_wr", 32'(lsq_o.sq_wr), 32'(en && commit && is_st));
            check_val("pfu_jump_o", 32'(pfu_jump_o), 32'(exp_jump));
            if (wb_o.wr) begin
                // link writes the address of the next instruction
                if (m_ins.link) begin
                    exp_data = m_ins.pc + 32'(m_ins.ins_size) * 32'd2;
                end else begin
                    exp_data = res.data;
                end
                check_val("wb_o.addr", 32'(wb_o.addr), 32'(m_ins.regd_addr));
                check_val("wb_o.data", wb_o.data, exp_data);
            end
            if (lsq_o.lq_wr || lsq_o.sq_wr) begin
                check_val("lsq_o.addr", lsq_o.addr, res.data);
                check_val("lsq_o.funct3", 32'(lsq_o.funct3), 32'(m_ins.funct3));
                check_val("lsq_o.regd_addr", 32'(lsq_o.regd_addr), 32'(m_ins.regd_addr));
                check_val("lsq_o.regs2_data", lsq_o.regs2_data, m_ins.regs2_data);
            end
            if (exp_jump) begin
                check_val("pfu_jump_addr_o", pfu_jump_addr_o, res.data & 32'hffff_fffe);
            end
            // state after the coming edge
            if (en) begin
                if (exp_jump) begin
                    m_run = 1'b0;
                end else if (dec_ins_i.valid && dec_ins_i.sof == SOF_JUMP) begin
                    m_run = 1'b1;
                end
                m_valid = dec_ins_i.valid;
                m_ins   = dec_ins_i;
            end
            taken = en;
        end
    end

endmodule

// File: project.f
verilog/ex_pkg.sv
verilog/ex_issue_reg.sv
verilog/ex_alu.sv
verilog/ex_commit.sv
verilog/ex_stage.sv
bench/tb_ex_stage.sv

// File: run.sh
#!/bin/sh
verilator --binary --timing --assert -f project.f --top-module tb_ex_stage -Mdir obj_dir \
    || exit 1
out=$(./obj_dir/Vtb_ex_stage)
echo "$out"
echo "$out" | grep -q "Result: PASSED" && exit 0 || exit 1
